/* common/cw_bridge_pkg.sv */
`default_nettype none
////////////////////////////////////////////////////////////
// Register map, AHB-Lite codes and payload types shared
// by the register bridge
////////////////////////////////////////////////////////////

package cw_bridge_pkg;

   // Host register offsets
   localparam logic [7:0] REG_CLKSETTINGS    = 8'h00;
   localparam logic [7:0] REG_USER_LED       = 8'h01;
   localparam logic [7:0] REG_CRYPT_TYPE     = 8'h02;
   localparam logic [7:0] REG_CRYPT_REV      = 8'h03;
   localparam logic [7:0] REG_IDENTIFY       = 8'h04;
   localparam logic [7:0] REG_CRYPT_WR       = 8'h06;
   localparam logic [7:0] REG_CRYPT_RD       = 8'h07;
   localparam logic [7:0] REG_CRYPT_ADDR     = 8'h08;
   localparam logic [7:0] REG_CRYPT_CTRL     = 8'h09;

   // Returned for any offset outside the map
   localparam logic [7:0] UNMAPPED_READ_DATA = 8'h5A;

   // Control register commands and status
   localparam logic [7:0] CMD_WRITE          = 8'd1;
   localparam logic [7:0] CMD_READ           = 8'd2;
   localparam int         CTRL_ERROR_BIT     = 7;

   // AHB-Lite bus widths and codes
   localparam int         AHB_ADDR_W         = 32;
   localparam int         AHB_DATA_W         = 32;
   localparam logic [1:0] HTRANS_IDLE        = 2'b00;
   localparam logic [1:0] HTRANS_NONSEQ      = 2'b10;
   localparam logic [2:0] HSIZE_WORD         = 3'b010;

   // One single-beat transfer request
   typedef struct packed {
      logic                  write;
      logic [AHB_ADDR_W-1:0] addr;
      logic [AHB_DATA_W-1:0] wdata;
   } ahb_req_t;

   // Result of one transfer
   typedef struct packed {
      logic                  error;
      logic [AHB_DATA_W-1:0] rdata;
   } ahb_rsp_t;

endpackage

`default_nettype wire

/* source/stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// One-entry valid/ready pipeline slot for any payload type
////////////////////////////////////////////////////////////

module stage_reg #(
   parameter type payload_t = logic
) (
   input  wire           crypto_clk,
   input  wire           reset_i,
   // Upstream side
   input  wire           in_valid_i,
   output logic          in_ready_o,
   input  wire payload_t in_data_i,
   // Downstream side
   output logic          out_valid_o,
   input  wire           out_ready_i,
   output payload_t      out_data_o
);

   logic     valid_q;
   payload_t data_q;

   // Slot is free when empty or when its beat leaves this cycle
   assign in_ready_o = !valid_q || out_ready_i;

   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         valid_q <= 1'b0;
      end else if (in_valid_i && in_ready_o) begin
         valid_q <= 1'b1;
      end else if (out_ready_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge crypto_clk) begin
      if (in_valid_i && in_ready_o) begin
         data_q <= in_data_i;
      end
   end

   assign out_valid_o = valid_q;
   assign out_data_o  = data_q;

   // Stalled beat stays put until the consumer takes it
   assert property (@(posedge crypto_clk) disable iff (reset_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
      else $error("stage_reg beat changed while stalled");

endmodule

`default_nettype wire

/* reg_frontend/reg_frontend.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// Byte-wide host register file, launches one AHB transfer
// per command and collects its result
////////////////////////////////////////////////////////////

module reg_frontend import cw_bridge_pkg::*; #(
   parameter logic [7:0] CRYPT_TYPE = 8'h03,
   parameter logic [7:0] CRYPT_REV  = 8'h01,
   parameter logic [7:0] IDENTIFY   = 8'h2E
) (
   input  wire           crypto_clk,
   input  wire           reset_i,
   // Host register bus
   input  wire [7:0]     reg_address_i,
   input  wire [7:0]     reg_bytecnt_i,
   input  wire [7:0]     write_data_i,
   input  wire           reg_read_i,
   input  wire           reg_write_i,
   input  wire           reg_addrvalid_i,
   output logic [7:0]    read_data_o,
   // Board registers
   output logic [4:0]    clksettings_o,
   output logic          user_led_o,
   // Request towards the master
   output logic          req_valid_o,
   input  wire           req_ready_i,
   output ahb_req_t      req_o,
   // Response from the master
   input  wire           rsp_valid_i,
   output logic          rsp_ready_o,
   input  wire ahb_rsp_t rsp_i
);

   logic [AHB_DATA_W-1:0] wr_q;
   logic [AHB_DATA_W-1:0] rd_q;
   logic [AHB_ADDR_W-1:0] addr_q;
   logic [7:0]            ctrl_q;
   logic                  req_valid_q;
   ahb_req_t              req_q;
   logic [7:0]            rdata_mux;
   logic [1:0]            byte_sel;
   logic                  host_wr;
   logic                  host_rd;
   logic                  busy;
   logic                  launch;
   logic                  rsp_fire;

   assign host_wr  = reg_addrvalid_i && reg_write_i;
   assign host_rd  = reg_addrvalid_i && reg_read_i;
   assign byte_sel = reg_bytecnt_i[1:0];

   // Error bit alone does not count as an open command
   assign busy     = |ctrl_q[CTRL_ERROR_BIT-1:0];
   assign launch   = host_wr && (reg_address_i == REG_CRYPT_CTRL) && !busy &&
                     (write_data_i == CMD_WRITE || write_data_i == CMD_READ);

   // Take the response only once the request has left
   assign rsp_ready_o = busy && !req_valid_q;
   assign rsp_fire    = rsp_valid_i && rsp_ready_o;

   ////////////////////////////////////////////////////////////
   // Host reads
   ////////////////////////////////////////////////////////////

   always_comb begin
      rdata_mux = 8'h00;
      if (host_rd) begin
         case (reg_address_i)
            REG_CLKSETTINGS: rdata_mux = {3'b000, clksettings_o};
            REG_USER_LED:    rdata_mux = {7'b0000000, user_led_o};
            REG_CRYPT_TYPE:  rdata_mux = CRYPT_TYPE;
            REG_CRYPT_REV:   rdata_mux = CRYPT_REV;
            REG_IDENTIFY:    rdata_mux = IDENTIFY;
            REG_CRYPT_WR:    rdata_mux = wr_q[byte_sel*8 +: 8];
            REG_CRYPT_RD:    rdata_mux = rd_q[byte_sel*8 +: 8];
            REG_CRYPT_ADDR:  rdata_mux = addr_q[byte_sel*8 +: 8];
            REG_CRYPT_CTRL:  rdata_mux = ctrl_q;
            default:         rdata_mux = UNMAPPED_READ_DATA;
         endcase
      end
   end

   // Read data one cycle after the strobe
   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         read_data_o <= 8'h00;
      end else begin
         read_data_o <= rdata_mux;
      end
   end

   ////////////////////////////////////////////////////////////
   // Host writes and command control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         clksettings_o <= 5'b00000;
         user_led_o    <= 1'b0;
         ctrl_q        <= 8'h00;
         req_valid_q   <= 1'b0;
      end else begin
         if (host_wr && reg_address_i == REG_CLKSETTINGS) begin
            clksettings_o <= write_data_i[4:0];
         end
         if (host_wr && reg_address_i == REG_USER_LED) begin
            user_led_o <= write_data_i[0];
         end
         if (launch) begin
            ctrl_q      <= write_data_i;
            req_valid_q <= 1'b1;
         end else if (req_valid_q && req_ready_i) begin
            req_valid_q <= 1'b0;
         end else if (rsp_fire) begin
            // Leave only the error flag behind
            ctrl_q                 <= 8'h00;
            ctrl_q[CTRL_ERROR_BIT] <= rsp_i.error;
         end
      end
   end

   // Byte lanes, request snapshot and read-back word
   always_ff @(posedge crypto_clk) begin
      if (host_wr && reg_address_i == REG_CRYPT_WR) begin
         wr_q[byte_sel*8 +: 8] <= write_data_i;
      end
      if (host_wr && reg_address_i == REG_CRYPT_ADDR) begin
         addr_q[byte_sel*8 +: 8] <= write_data_i;
      end
      if (launch) begin
         req_q.write <= (write_data_i == CMD_WRITE);
         req_q.addr  <= addr_q;
         req_q.wdata <= wr_q;
      end
      if (rsp_fire && !rsp_i.error && ctrl_q == CMD_READ) begin
         rd_q <= rsp_i.rdata;
      end
   end

   assign req_valid_o = req_valid_q;
   assign req_o       = req_q;

   // No request may exist without an accepted command
   assert property (@(posedge crypto_clk) disable iff (reset_i)
      req_valid_o |-> ctrl_q != 8'h00)
      else $error("request raised with control register clear");

endmodule

`default_nettype wire

/* ahb_master/ahb_master.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// AHB-Lite master running one single-beat transfer per request
////////////////////////////////////////////////////////////

module ahb_master import cw_bridge_pkg::*; (
   input  wire                   crypto_clk,
   input  wire                   reset_i,
   // Request in
   input  wire                   req_valid_i,
   output logic                  req_ready_o,
   input  wire ahb_req_t         req_i,
   // Response out
   output logic                  rsp_valid_o,
   input  wire                   rsp_ready_i,
   output ahb_rsp_t              rsp_o,
   // AHB-Lite master side
   output logic [AHB_ADDR_W-1:0] haddr_o,
   output logic [AHB_DATA_W-1:0] hwdata_o,
   output logic                  hsel_o,
   output logic                  hwrite_o,
   output logic [1:0]            htrans_o,
   output logic [2:0]            hsize_o,
   output logic                  hready_o,
   input  wire                   hreadyout_i,
   input  wire                   hresp_i,
   input  wire [AHB_DATA_W-1:0]  hrdata_i
);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA,
      DONE
   } state_t;

   state_t   state_q;
   state_t   state_d;
   ahb_req_t req_q;
   ahb_rsp_t rsp_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: if (req_valid_i) state_d = ADDR;
         // Address phase lasts until the target is ready
         ADDR: if (hreadyout_i) state_d = DATA;
         DATA: if (hreadyout_i) state_d = DONE;
         // Hold here while the response stage is full
         DONE: if (rsp_ready_i) state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge crypto_clk) begin
      if (state_q == IDLE && req_valid_i) begin
         req_q <= req_i;
      end
      if (state_q == DATA && hreadyout_i) begin
         rsp_q.error <= hresp_i;
         rsp_q.rdata <= req_q.write ? '0 : hrdata_i;
      end
   end

   assign req_ready_o = (state_q == IDLE);
   assign rsp_valid_o = (state_q == DONE);
   assign rsp_o       = rsp_q;

   // Bus drive, zero whenever no phase owns a field
   assign hsel_o   = (state_q == ADDR);
   assign htrans_o = (state_q == ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign haddr_o  = (state_q == ADDR) ? req_q.addr : '0;
   assign hwrite_o = (state_q == ADDR) && req_q.write;
   assign hwdata_o = (state_q == DATA) ? req_q.wdata : '0;
   assign hsize_o  = HSIZE_WORD;
   // Single target, so its ready is the bus ready
   assign hready_o = hreadyout_i;

   assert property (@(posedge crypto_clk) disable iff (reset_i)
      htrans_o == HTRANS_NONSEQ |-> hsel_o)
      else $error("NONSEQ transfer without hsel");

   // A stalled address phase keeps its address and type
   assert property (@(posedge crypto_clk) disable iff (reset_i)
      htrans_o == HTRANS_NONSEQ && !hreadyout_i |=>
         htrans_o == HTRANS_NONSEQ && $stable(haddr_o))
      else $error("address phase dropped before hreadyout");

endmodule

`default_nettype wire

/* source/ahb_sram_target.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// AHB-Lite word memory with wait states and error response
////////////////////////////////////////////////////////////

module ahb_sram_target import cw_bridge_pkg::*; #(
   parameter int MEM_WORDS   = 64,
   parameter int WAIT_STATES = 2
) (
   input  wire                   crypto_clk,
   input  wire                   reset_i,
   input  wire [AHB_ADDR_W-1:0]  haddr_i,
   input  wire [AHB_DATA_W-1:0]  hwdata_i,
   input  wire                   hsel_i,
   input  wire                   hwrite_i,
   input  wire [1:0]             htrans_i,
   input  wire [2:0]             hsize_i,
   input  wire                   hready_i,
   output logic                  hreadyout_o,
   output logic                  hresp_o,
   output logic [AHB_DATA_W-1:0] hrdata_o
);

   localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
   localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   logic [AHB_DATA_W-1:0] mem [MEM_WORDS];
   logic [IDX_W-1:0]      idx_q;
   logic                  write_q;
   logic                  dphase_q;
   logic [CNT_W-1:0]      wait_q;
   logic                  err_q;
   logic                  err2_q;
   logic                  addr_phase;
   logic                  bad_access;
   logic                  last_cycle;

   assign addr_phase = hsel_i && hready_i && (htrans_i == HTRANS_NONSEQ);

   // Out of range, misaligned or not a full word
   assign bad_access = (haddr_i[AHB_ADDR_W-1:2] >= MEM_WORDS) ||
                       (haddr_i[1:0] != 2'b00) || (hsize_i != HSIZE_WORD);

   assign last_cycle = dphase_q && (wait_q == '0) && (!err_q || err2_q);

   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         dphase_q <= 1'b0;
         wait_q   <= '0;
         err_q    <= 1'b0;
         err2_q   <= 1'b0;
      end else if (addr_phase) begin
         dphase_q <= 1'b1;
         wait_q   <= CNT_W'(WAIT_STATES);
         err_q    <= bad_access;
         err2_q   <= 1'b0;
      end else if (dphase_q) begin
         if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
         end else if (err_q && !err2_q) begin
            err2_q <= 1'b1;
         end else begin
            dphase_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge crypto_clk) begin
      if (addr_phase) begin
         idx_q   <= haddr_i[IDX_W+1:2];
         write_q <= hwrite_i;
      end
      if (last_cycle && write_q && !err_q) begin
         mem[idx_q] <= hwdata_i;
      end
   end

   assign hreadyout_o = !dphase_q || last_cycle;
   assign hresp_o     = dphase_q && err_q && (wait_q == '0);
   assign hrdata_o    = (dphase_q && !err_q && !write_q) ? mem[idx_q] : '0;

   // Error is two cycles, not ready first, then ready
   assert property (@(posedge crypto_clk) disable iff (reset_i)
      hresp_o && !hreadyout_o |=> hresp_o && hreadyout_o)
      else $error("malformed two-cycle error response");

endmodule

`default_nettype wire

/* source/cw_ahb_bridge_top.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// Register bridge top with stage registers and memory target
////////////////////////////////////////////////////////////

module cw_ahb_bridge_top import cw_bridge_pkg::*; #(
   parameter logic [7:0] CRYPT_TYPE  = 8'h03,
   parameter logic [7:0] CRYPT_REV   = 8'h01,
   parameter logic [7:0] IDENTIFY    = 8'h2E,
   parameter int         MEM_WORDS   = 64,
   parameter int         WAIT_STATES = 2
) (
   input  wire        crypto_clk,
   input  wire        reset_i,
   input  wire [7:0]  reg_address_i,
   input  wire [7:0]  reg_bytecnt_i,
   input  wire [7:0]  write_data_i,
   input  wire        reg_read_i,
   input  wire        reg_write_i,
   input  wire        reg_addrvalid_i,
   output logic [7:0] read_data_o,
   output logic [4:0] clksettings_o,
   output logic       user_led_o
);

   // Frontend to request stage
   logic     fe_req_valid;
   logic     fe_req_ready;
   ahb_req_t fe_req;
   // Request stage to master
   logic     m_req_valid;
   logic     m_req_ready;
   ahb_req_t m_req;
   // Master to response stage
   logic     m_rsp_valid;
   logic     m_rsp_ready;
   ahb_rsp_t m_rsp;
   // Response stage to frontend
   logic     fe_rsp_valid;
   logic     fe_rsp_ready;
   ahb_rsp_t fe_rsp;

   // AHB-Lite bus
   logic [AHB_ADDR_W-1:0] haddr;
   logic [AHB_DATA_W-1:0] hwdata;
   logic [AHB_DATA_W-1:0] hrdata;
   logic                  hsel;
   logic                  hwrite;
   logic [1:0]            htrans;
   logic [2:0]            hsize;
   logic                  hready;
   logic                  hreadyout;
   logic                  hresp;

   reg_frontend #(
      .CRYPT_TYPE (CRYPT_TYPE),
      .CRYPT_REV  (CRYPT_REV),
      .IDENTIFY   (IDENTIFY)
   ) u_reg_frontend (
      .crypto_clk      (crypto_clk),
      .reset_i         (reset_i),
      .reg_address_i   (reg_address_i),
      .reg_bytecnt_i   (reg_bytecnt_i),
      .write_data_i    (write_data_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .reg_addrvalid_i (reg_addrvalid_i),
      .read_data_o     (read_data_o),
      .clksettings_o   (clksettings_o),
      .user_led_o      (user_led_o),
      .req_valid_o     (fe_req_valid),
      .req_ready_i     (fe_req_ready),
      .req_o           (fe_req),
      .rsp_valid_i     (fe_rsp_valid),
      .rsp_ready_o     (fe_rsp_ready),
      .rsp_i           (fe_rsp)
   );

   stage_reg #(
      .payload_t (ahb_req_t)
   ) u_req_stage (
      .crypto_clk  (crypto_clk),
      .reset_i     (reset_i),
      .in_valid_i  (fe_req_valid),
      .in_ready_o  (fe_req_ready),
      .in_data_i   (fe_req),
      .out_valid_o (m_req_valid),
      .out_ready_i (m_req_ready),
      .out_data_o  (m_req)
   );

   ahb_master u_ahb_master (
      .crypto_clk  (crypto_clk),
      .reset_i     (reset_i),
      .req_valid_i (m_req_valid),
      .req_ready_o (m_req_ready),
      .req_i       (m_req),
      .rsp_valid_o (m_rsp_valid),
      .rsp_ready_i (m_rsp_ready),
      .rsp_o       (m_rsp),
      .haddr_o     (haddr),
      .hwdata_o    (hwdata),
      .hsel_o      (hsel),
      .hwrite_o    (hwrite),
      .htrans_o    (htrans),
      .hsize_o     (hsize),
      .hready_o    (hready),
      .hreadyout_i (hreadyout),
      .hresp_i     (hresp),
      .hrdata_i    (hrdata)
   );

   stage_reg #(
      .payload_t (ahb_rsp_t)
   ) u_rsp_stage (
      .crypto_clk  (crypto_clk),
      .reset_i     (reset_i),
      .in_valid_i  (m_rsp_valid),
      .in_ready_o  (m_rsp_ready),
      .in_data_i   (m_rsp),
      .out_valid_o (fe_rsp_valid),
      .out_ready_i (fe_rsp_ready),
      .out_data_o  (fe_rsp)
   );

   ahb_sram_target #(
      .MEM_WORDS   (MEM_WORDS),
      .WAIT_STATES (WAIT_STATES)
   ) u_ahb_sram_target (
      .crypto_clk  (crypto_clk),
      .reset_i     (reset_i),
      .haddr_i     (haddr),
      .hwdata_i    (hwdata),
      .hsel_i      (hsel),
      .hwrite_i    (hwrite),
      .htrans_i    (htrans),
      .hsize_i     (hsize),
      .hready_i    (hready),
      .hreadyout_o (hreadyout),
      .hresp_o     (hresp),
      .hrdata_o    (hrdata)
   );

endmodule

`default_nettype wire

/* sim/tb_cw_ahb_bridge.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// Directed testbench for the register to AHB-Lite bridge
////////////////////////////////////////////////////////////

module tb_cw_ahb_bridge import cw_bridge_pkg::*;;

   localparam int         MEM_WORDS   = 64;
   localparam int         WAIT_STATES = 2;
   localparam logic [7:0] CRYPT_TYPE  = 8'h03;
   localparam logic [7:0] CRYPT_REV   = 8'h01;
   localparam logic [7:0] IDENTIFY    = 8'h2E;
   localparam int         MAX_POLLS   = 200;

   logic       crypto_clk = 1'b0;
   logic       reset_i;
   logic [7:0] reg_address_i;
   logic [7:0] reg_bytecnt_i;
   logic [7:0] write_data_i;
   logic       reg_read_i;
   logic       reg_write_i;
   logic       reg_addrvalid_i;
   logic [7:0] read_data_o;
   logic [4:0] clksettings_o;
   logic       user_led_o;

   // Reference copy of the target memory
   logic [AHB_DATA_W-1:0] ref_mem [MEM_WORDS];
   logic                  ref_valid [MEM_WORDS];

   int          error_count = 0;
   int          check_count = 0;
   int          test_count  = 0;
   int unsigned seed_val;

   always #5 crypto_clk = ~crypto_clk;

   cw_ahb_bridge_top #(
      .CRYPT_TYPE  (CRYPT_TYPE),
      .CRYPT_REV   (CRYPT_REV),
      .IDENTIFY    (IDENTIFY),
      .MEM_WORDS   (MEM_WORDS),
      .WAIT_STATES (WAIT_STATES)
   ) u_cw_ahb_bridge_top (
      .crypto_clk      (crypto_clk),
      .reset_i         (reset_i),
      .reg_address_i   (reg_address_i),
      .reg_bytecnt_i   (reg_bytecnt_i),
      .write_data_i    (write_data_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .reg_addrvalid_i (reg_addrvalid_i),
      .read_data_o     (read_data_o),
      .clksettings_o   (clksettings_o),
      .user_led_o      (user_led_o)
   );

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_byte(input string msg, input logic [7:0] got, input logic [7:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH at %0t: %s got 0x%02h expected 0x%02h", $time, msg, got, exp);
      end
   endtask

   task automatic check_word(input string msg, input logic [AHB_DATA_W-1:0] got,
                             input logic [AHB_DATA_W-1:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, msg, got, exp);
      end
   endtask

   // Idle control byte holds nothing but the error flag
   task automatic check_status(input string msg, input logic [7:0] got, input logic exp_err);
      logic [7:0] exp;
      exp = 8'h00;
      exp[CTRL_ERROR_BIT] = exp_err;
      check_byte(msg, got, exp);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      test_count++;
      if (error_count == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d mismatches", name, error_count - errors_before);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Host register bus
   ////////////////////////////////////////////////////////////

   // Strobes go up 1 ns after an edge and drop after the next one
   task automatic host_write(input logic [7:0] addr, input logic [7:0] cnt,
                             input logic [7:0] data);
      reg_address_i   = addr;
      reg_bytecnt_i   = cnt;
      write_data_i    = data;
      reg_write_i     = 1'b1;
      reg_addrvalid_i = 1'b1;
      @(posedge crypto_clk);
      #1;
      reg_write_i     = 1'b0;
      reg_addrvalid_i = 1'b0;
   endtask

   // Read data is registered on the strobe edge
   task automatic host_read(input logic [7:0] addr, input logic [7:0] cnt,
                            output logic [7:0] data);
      reg_address_i   = addr;
      reg_bytecnt_i   = cnt;
      reg_read_i      = 1'b1;
      reg_addrvalid_i = 1'b1;
      @(posedge crypto_clk);
      #1;
      data            = read_data_o;
      reg_read_i      = 1'b0;
      reg_addrvalid_i = 1'b0;
   endtask

   task automatic write_word(input logic [7:0] addr, input logic [31:0] value);
      for (int b = 0; b < 4; b++) begin
         host_write(addr, 8'(b), value[b*8 +: 8]);
      end
   endtask

   task automatic read_word(input logic [7:0] addr, output logic [31:0] value);
      logic [7:0] byte_val;
      for (int b = 0; b < 4; b++) begin
         host_read(addr, 8'(b), byte_val);
         value[b*8 +: 8] = byte_val;
      end
   endtask

   task automatic wait_idle(output logic [7:0] ctrl);
      int         polls;
      logic [7:0] value;
      polls = 0;
      value = 8'hFF;
      while (polls < MAX_POLLS && value[CTRL_ERROR_BIT-1:0] != '0) begin
         host_read(REG_CRYPT_CTRL, 8'h00, value);
         polls++;
      end
      if (value[CTRL_ERROR_BIT-1:0] != '0) begin
         $display("ERROR: transfer did not complete within %0d polls of CTRL", MAX_POLLS);
         $display("STATUS: FAIL");
         $finish;
      end else begin
         ctrl = value;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // AHB transfers through the control register
   ////////////////////////////////////////////////////////////

   task automatic ahb_write(input int unsigned idx, input logic [31:0] data,
                            output logic [7:0] status);
      write_word(REG_CRYPT_WR, data);
      write_word(REG_CRYPT_ADDR, 32'(idx) << 2);
      host_write(REG_CRYPT_CTRL, 8'h00, CMD_WRITE);
      wait_idle(status);
   endtask

   task automatic ahb_read(input int unsigned idx, output logic [7:0] status,
                           output logic [31:0] rd_word);
      write_word(REG_CRYPT_ADDR, 32'(idx) << 2);
      host_write(REG_CRYPT_CTRL, 8'h00, CMD_READ);
      wait_idle(status);
      read_word(REG_CRYPT_RD, rd_word);
   endtask

   task automatic store_ref(input int unsigned idx, input logic [31:0] data,
                            input logic [7:0] status);
      check_status("write status", status, 1'b0);
      ref_mem[idx]   = data;
      ref_valid[idx] = 1'b1;
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic reset_values();
      int         start;
      logic [7:0] value;
      start = error_count;
      host_read(REG_CLKSETTINGS, 8'h00, value);
      check_byte("CLKSETTINGS after reset", value, 8'h00);
      host_read(REG_USER_LED, 8'h00, value);
      check_byte("USER_LED after reset", value, 8'h00);
      host_read(REG_CRYPT_CTRL, 8'h00, value);
      check_byte("CTRL after reset", value, 8'h00);
      host_read(REG_CRYPT_TYPE, 8'h00, value);
      check_byte("TYPE", value, CRYPT_TYPE);
      host_read(REG_CRYPT_REV, 8'h00, value);
      check_byte("REV", value, CRYPT_REV);
      host_read(REG_IDENTIFY, 8'h00, value);
      check_byte("IDENTIFY", value, IDENTIFY);
      check_byte("clksettings_o after reset", {3'b000, clksettings_o}, 8'h00);
      check_byte("user_led_o after reset", {7'b0000000, user_led_o}, 8'h00);
      finish_test("reset_values", start);
   endtask

   task automatic board_registers();
      int         start;
      logic [7:0] value;
      start = error_count;
      host_write(REG_CLKSETTINGS, 8'h00, 8'hEB);
      host_read(REG_CLKSETTINGS, 8'h00, value);
      check_byte("CLKSETTINGS masked", value, 8'h0B);
      check_byte("clksettings_o", {3'b000, clksettings_o}, 8'h0B);
      host_write(REG_USER_LED, 8'hFF, 8'hFF);
      host_read(REG_USER_LED, 8'h00, value);
      check_byte("USER_LED masked", value, 8'h01);
      check_byte("user_led_o", {7'b0000000, user_led_o}, 8'h01);
      host_read(8'h0C, 8'h00, value);
      check_byte("unmapped offset", value, 8'h5A);
      finish_test("board_registers", start);
   endtask

   task automatic byte_registers();
      int          start;
      logic [31:0] value;
      start = error_count;
      write_word(REG_CRYPT_WR, 32'hA5C3_1E7F);
      write_word(REG_CRYPT_ADDR, 32'h1234_5678);
      read_word(REG_CRYPT_WR, value);
      check_word("WR read back", value, 32'hA5C3_1E7F);
      read_word(REG_CRYPT_ADDR, value);
      check_word("ADDR read back", value, 32'h1234_5678);
      finish_test("byte_registers", start);
   endtask

   task automatic write_readback();
      int          start;
      logic [7:0]  status;
      logic [31:0] rd_word;
      start = error_count;
      ahb_write(5, 32'hDEAD_BEEF, status);
      store_ref(5, 32'hDEAD_BEEF, status);
      ahb_read(5, status, rd_word);
      check_status("read status", status, 1'b0);
      check_word("RD after write", rd_word, 32'hDEAD_BEEF);
      finish_test("write_readback", start);
   endtask

   // A read steps on to the next word that the model already knows
   task automatic random_traffic();
      int          start;
      int unsigned idx;
      logic        do_read;
      logic [7:0]  status;
      logic [31:0] data;
      logic [31:0] rd_word;
      start = error_count;
      for (int i = 0; i < 20; i++) begin
         idx     = $urandom % MEM_WORDS;
         data    = $urandom;
         do_read = ($urandom % 2 == 1);
         if (do_read) begin
            for (int k = 0; k < MEM_WORDS && !ref_valid[idx]; k++) begin
               idx = (idx + 1) % MEM_WORDS;
            end
         end
         if (do_read && ref_valid[idx]) begin
            ahb_read(idx, status, rd_word);
            check_status("random read status", status, 1'b0);
            check_word("random read data", rd_word, ref_mem[idx]);
         end else begin
            ahb_write(idx, data, status);
            store_ref(idx, data, status);
         end
      end
      finish_test("random_traffic", start);
   endtask

   task automatic out_of_range();
      int          start;
      logic [7:0]  status;
      logic [31:0] rd_word;
      logic [31:0] prev_rd;
      start = error_count;
      ahb_write(0, 32'h0BAD_F00D, status);
      store_ref(0, 32'h0BAD_F00D, status);
      ahb_read(5, status, prev_rd);
      check_word("RD before error", prev_rd, ref_mem[5]);
      // Word 64 shares its low index bits with word 0
      ahb_write(MEM_WORDS, 32'hFFFF_0000, status);
      check_status("out of range write", status, 1'b1);
      ahb_read(MEM_WORDS + 36, status, rd_word);
      check_status("out of range read", status, 1'b1);
      check_word("RD kept after error", rd_word, prev_rd);
      ahb_read(0, status, rd_word);
      check_status("read after error", status, 1'b0);
      check_word("word 0 untouched", rd_word, ref_mem[0]);
      finish_test("out_of_range", start);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      seed_val        = $urandom(55973);
      reset_i         = 1'b1;
      reg_address_i   = 8'h00;
      reg_bytecnt_i   = 8'h00;
      write_data_i    = 8'h00;
      reg_read_i      = 1'b0;
      reg_write_i     = 1'b0;
      reg_addrvalid_i = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i]   = '0;
         ref_valid[i] = 1'b0;
      end
      repeat (10) @(posedge crypto_clk);
      #1;
      reset_i = 1'b0;

      reset_values();
      board_registers();
      byte_registers();
      write_readback();
      random_traffic();
      out_of_range();

      $display("tests %0d, checks %0d, mismatches %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
common/cw_bridge_pkg.sv
source/stage_reg.sv
reg_frontend/reg_frontend.sv
ahb_master/ahb_master.sv
source/ahb_sram_target.sv
source/cw_ahb_bridge_top.sv
sim/tb_cw_ahb_bridge.sv

/* Bender.yml */
package:
  name: cw_ahb_bridge

sources:
  - common/cw_bridge_pkg.sv
  - source/stage_reg.sv
  - reg_frontend/reg_frontend.sv
  - ahb_master/ahb_master.sv
  - source/ahb_sram_target.sv
  - source/cw_ahb_bridge_top.sv
  - target: simulation
    files:
      - sim/tb_cw_ahb_bridge.sv
